// File: rv_soc.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/wb_pkg.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_cpu.sv
hdl/wb_ram.sv
hdl/rv_soc.sv
tb/rv_checker.sv
tb/tb_rv_soc.sv

// File: Bender.yml
package:
  name: rv_soc

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/wb_pkg.sv
      - hdl/rv_regfile.sv
      - hdl/rv_alu.sv
      - hdl/rv_cpu.sv
      - hdl/wb_ram.sv
      - hdl/rv_soc.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/rv_checker.sv
      - tb/tb_rv_soc.sv

// File: tb/tb_rv_soc.sv
`include "rv_macros.svh"

module tb_rv_soc
    import rv_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] NOP = 32'h0000_0013;    // addi x0, x0, 0.

    logic        clk_i;
    logic        rst_i;
    logic        load_we_i;
    logic [31:0] load_addr_i;
    logic [31:0] load_data_i;
    retire_t     retire_o;
    logic        halt_o;
    int          retire_cnt;
    int          err_cnt;

    logic [31:0] prog [0:`RV_MEM_WORDS-1];
    int          wp;
    int          n_exec;    // retires the program is expected to produce.
    int          seed = 32'hb1af;
    int          pass_cnt;
    int          fail_cnt;

    rv_soc u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .retire_o    (retire_o),
        .halt_o      (halt_o)
    );

    rv_checker u_chk (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_we_i    (load_we_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .retire_i     (retire_o),
        .halt_i       (halt_o),
        .retire_cnt_o (retire_cnt),
        .err_cnt_o    (err_cnt)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(32'd1 + ($unsigned($random(seed)) % 32'd31));    // x1 to x31.
    endfunction

    function automatic logic [31:0] enc_r(input logic f7b5, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic emit(input logic [31:0] insn);
        prog[wp] = insn;
        wp++;
        n_exec++;
    endtask

    task automatic new_program(input bit with_init);
        for (int a = 0; a < `RV_MEM_WORDS; a++) begin
            prog[a] = NOP;
        end
        wp     = 0;
        n_exec = 0;
        if (with_init) begin
            for (int r = 1; r < 32; r++) begin
                emit(enc_u(20'(rand_word() >> 12), 5'(r), LUI));
                emit(enc_i(12'(rand_word() >> 20), 5'(r), 3'd0, 5'(r), OP_IMM));
            end
        end
    endtask

    task automatic gen_op_test();
        logic [31:0] w;
        logic [2:0]  f3;
        new_program(1'b1);
        for (int i = 0; i < 40; i++) begin
            w  = rand_word();
            f3 = 3'(i);
            emit(enc_r((f3 == 3'd0 || f3 == 3'd5) && w[7], rand_reg(), rand_reg(), f3,
                       rand_reg()));
        end
    endtask

    task automatic gen_imm_test();
        logic [31:0] w;
        logic [2:0]  f3;
        new_program(1'b1);
        for (int i = 0; i < 40; i++) begin
            w  = rand_word();
            f3 = 3'(i);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                w[11:0] = {1'b0, (f3 == 3'd5) && w[10], 5'b0, w[4:0]};    // shamt form.
            end
            emit(enc_i(w[11:0], rand_reg(), f3, rand_reg(), OP_IMM));
        end
    endtask

    task automatic gen_upper_test();
        logic [31:0] w;
        new_program(1'b1);
        for (int i = 0; i < 30; i++) begin
            w = rand_word();
            emit(enc_u(w[31:12], rand_reg(), (i % 2 == 1) ? AUIPC : LUI));
        end
    endtask

    task automatic gen_jump_test();
        logic [31:0] w;
        logic [4:0]  base;
        int          skip;
        new_program(1'b1);
        for (int i = 0; i < 12; i++) begin
            w    = rand_word();
            skip = w[1:0];
            if (w[8]) begin
                emit(enc_j(21'(4 * (1 + skip)), rand_reg()));
            end else begin
                base = rand_reg();
                emit(enc_u(20'd0, base, AUIPC));
                // bit 0 of the offset is set now and then and must be cleared.
                emit(enc_i(12'(4 * (2 + skip) + w[9]), base, 3'd0, rand_reg(), JALR));
            end
            wp = wp + skip;    // skipped words stay nop.
            emit(enc_i(w[31:20], rand_reg(), 3'd0, rand_reg(), OP_IMM));
        end
    endtask

    task automatic gen_x0_test();
        logic [31:0] w;
        new_program(1'b1);
        for (int i = 0; i < 12; i++) begin
            w = rand_word();
            case (i % 4)
                0: emit(enc_r(1'b0, rand_reg(), rand_reg(), w[14:12], 5'd0));
                1: emit(enc_i(w[31:20], rand_reg(), 3'd0, 5'd0, OP_IMM));
                2: emit(enc_u(w[31:12], 5'd0, LUI));
                default: emit(enc_j(21'd4, 5'd0));
            endcase
            emit(enc_r(1'b0, 5'd0, 5'd0, 3'd6, rand_reg()));        // or rd, x0, x0.
            emit(enc_i(w[11:0], 5'd0, 3'd0, rand_reg(), OP_IMM));
        end
    endtask

    task automatic gen_halt_test();
        logic [31:0] w;
        new_program(1'b0);
        w = rand_word();
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, OP_IMM));
        emit(enc_r(1'b0, 5'd1, 5'd1, 3'd0, 5'd2));
        emit(enc_j(21'(4 * (`RV_MEM_WORDS - 2 + w[3:0])), 5'd3));    // lands past the RAM.
    endtask

    task automatic run_program(input string name, input bit expect_halt);
        int base_ret;
        int base_err;
        int cycles;
        bit ok;
        @(negedge clk_i);
        rst_i = 1'b1;
        repeat (5) @(negedge clk_i);
        for (int a = 0; a < `RV_MEM_WORDS; a++) begin    // reset spans the whole preload.
            load_we_i   = 1'b1;
            load_addr_i = a;
            load_data_i = prog[a];
            @(negedge clk_i);
        end
        load_we_i = 1'b0;
        base_ret  = retire_cnt;
        base_err  = err_cnt;
        rst_i     = 1'b0;
        ok        = 1'b1;
        cycles    = 0;
        while (retire_cnt - base_ret < n_exec && cycles < 200 * n_exec) begin
            @(negedge clk_i);
            cycles++;
        end
        if (retire_cnt - base_ret < n_exec) begin
            $display("%s: timed out with %0d of %0d instructions retired", name,
                     retire_cnt - base_ret, n_exec);
            ok = 1'b0;
        end else if (expect_halt) begin
            cycles = 0;
            while (!halt_o && cycles < 200) begin
                @(negedge clk_i);
                cycles++;
            end
            if (!halt_o) begin
                $display("%s: halt never rose after the fetch outside the RAM", name);
                ok = 1'b0;
            end else begin
                base_ret = retire_cnt;
                cycles   = 0;
                while (cycles < 50) begin
                    @(negedge clk_i);
                    cycles++;
                end
                if (retire_cnt != base_ret || !halt_o) begin
                    $display("%s: core did not stay halted", name);
                    ok = 1'b0;
                end
            end
        end else if (halt_o) begin
            $display("%s: core halted although every fetch was inside the RAM", name);
            ok = 1'b0;
        end
        if (err_cnt != base_err) begin
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %-14s %s, %0d mismatches", name, ok ? "ok" : "failed",
                 err_cnt - base_err);
    endtask

    initial begin
        rst_i       = 1'b1;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        gen_op_test();
        run_program("reg-reg", 1'b0);
        gen_imm_test();
        run_program("reg-imm", 1'b0);
        gen_upper_test();
        run_program("lui/auipc", 1'b0);
        gen_jump_test();
        run_program("jal/jalr", 1'b0);
        gen_x0_test();
        run_program("x0 writes", 1'b0);
        gen_halt_test();
        run_program("fetch error", 1'b1);
        $display("summary: %0d tests passed, %0d failed, %0d retires, %0d mismatches",
                 pass_cnt, fail_cnt, retire_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb/rv_checker.sv
`include "rv_macros.svh"

module rv_checker
    import rv_isa_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        load_we_i,
    input  logic [31:0] load_addr_i,
    input  logic [31:0] load_data_i,
    input  retire_t     retire_i,
    input  logic        halt_i,
    output int          retire_cnt_o,
    output int          err_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem_m [0:`RV_MEM_WORDS-1];    // image built from the load port.
    logic [31:0] regs_m [0:31];
    logic [31:0] pc_m;

    initial begin
        retire_cnt_o = 0;
        err_cnt_o    = 0;
        pc_m         = `RV_RESET_PC;
        for (int r = 0; r < 32; r++) begin
            regs_m[r] = '0;
        end
    end

    // executes one instruction on the model state.
    function automatic retire_t ref_step(input logic [31:0] pc, input logic [31:0] insn,
                                         output logic [31:0] next_pc);
        retire_t     r;
        logic [6:0]  opc;
        logic [31:0] imm_i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        opc     = insn[6:0];
        imm_i   = {{20{insn[31]}}, insn[31:20]};
        a       = regs_m[insn[19:15]];
        b       = (opc == OP) ? regs_m[insn[24:20]] : imm_i;
        next_pc = pc + 32'd4;
        case (insn[14:12])
            3'd0: res = (opc == OP && insn[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (insn[30]) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        r.valid = 1'b1;
        r.pc    = pc;
        r.rd    = insn[11:7];
        r.we    = 1'b1;
        case (opc)
            OP, OP_IMM: r.wdata = res;
            LUI:        r.wdata = {insn[31:12], 12'b0};
            AUIPC:      r.wdata = pc + {insn[31:12], 12'b0};
            JAL: begin
                r.wdata = pc + 32'd4;
                next_pc = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            end
            JALR: begin
                r.wdata = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: begin
                r.wdata = '0;
                r.we    = 1'b0;
            end
        endcase
        if (r.rd == 5'd0) begin
            r.we = 1'b0;
        end
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        if (actv !== expv) begin
            $display("[FAIL] %s expected %h actual %h (model pc %h)", name, expv, actv, pc_m);
            err_cnt_o++;
        end
    endtask

    always @(posedge clk_i) begin
        retire_t     want;
        logic [31:0] next_pc;
        if (load_we_i && load_addr_i < `RV_MEM_WORDS) begin
            mem_m[load_addr_i] = load_data_i;
        end
        if (retire_i.valid === 1'b1) begin
            retire_cnt_o++;
            if (halt_i === 1'b1) begin
                $display("an instruction retired while the core was halted");
                err_cnt_o++;
            end
            if (pc_m[31:2] >= `RV_MEM_WORDS) begin
                $display("retire seen although the model pc %h lies outside the RAM", pc_m);
                err_cnt_o++;
            end else begin
                want = ref_step(pc_m, mem_m[pc_m[31:2]], next_pc);
                check_field("pc", want.pc, retire_i.pc);
                check_field("rd", want.rd, retire_i.rd);
                check_field("we", want.we, retire_i.we);
                check_field("wdata", want.wdata, retire_i.wdata);
                if (want.we) begin
                    regs_m[want.rd] = want.wdata;
                end
                pc_m = next_pc;
            end
        end
        if (rst_i) begin
            pc_m = `RV_RESET_PC;
        end
    end

endmodule

// File: hdl/rv_soc.sv
module rv_soc
    import rv_isa_pkg::*;
    import wb_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        load_we_i,
    input  logic [31:0] load_addr_i,
    input  logic [31:0] load_data_i,
    output retire_t     retire_o,
    output logic        halt_o
);

    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    rv_cpu u_cpu (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_req_o (wb_req),
        .wb_rsp_i (wb_rsp),
        .retire_o (retire_o),
        .halt_o   (halt_o)
    );

    // program memory, preloaded while reset is held.
    wb_ram u_ram (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

endmodule

// File: hdl/wb_ram.sv
`include "rv_macros.svh"

module wb_ram
    import wb_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  wb_req_t     wb_req_i,
    output wb_rsp_t     wb_rsp_o,
    input  logic        load_we_i,
    input  logic [31:0] load_addr_i,    // word index.
    input  logic [31:0] load_data_i
);

    localparam int AW = $clog2(`RV_MEM_WORDS);

    logic [31:0]   mem [0:`RV_MEM_WORDS-1];
    logic [29:0]   word_idx;
    logic [AW-1:0] bus_idx;
    logic          in_range;
    logic          req;
    logic          ack_q;
    logic          err_q;
    logic [31:0]   dat_q;

    assign word_idx = wb_req_i.adr[31:2];
    assign bus_idx  = word_idx[AW-1:0];
    assign in_range = word_idx < `RV_MEM_WORDS;
    assign req      = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;  // one reply per cycle.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req && in_range;
            err_q <= req && !in_range;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_we_i && load_addr_i < `RV_MEM_WORDS) begin
            mem[load_addr_i[AW-1:0]] <= load_data_i;
        end else if (req && in_range && wb_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_req_i.sel[b]) begin
                    mem[bus_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
            end
        end
        if (req && in_range) begin
            dat_q <= mem[bus_idx];
        end
    end

    assign wb_rsp_o.dat = dat_q;
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = err_q;
    assign wb_rsp_o.rty = 1'b0;

endmodule

// File: hdl/rv_cpu.sv
`include "rv_macros.svh"

module rv_cpu
    import rv_isa_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    output wb_req_t wb_req_o,
    input  wb_rsp_t wb_rsp_i,
    output retire_t retire_o,
    output logic    halt_o
);

    cpu_state_e          state_q;
    logic [`RV_XLEN-1:0] pc_q;
    logic [31:0]         ir_q;
    logic [`RV_XLEN-1:0] rs1_q;
    logic [`RV_XLEN-1:0] rs2_q;
    logic [`RV_XLEN-1:0] alu_res_q;

    opcode_e             opcode;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] rf_rdata1;
    logic [`RV_XLEN-1:0] rf_rdata2;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] rd_wdata;
    logic                writes_rd;
    logic                rf_we;

    assign opcode = opcode_e'(ir_q[6:0]);
    assign rd     = ir_q[11:7];

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rd_addr1_i (ir_q[19:15]),
        .rd_addr2_i (ir_q[24:20]),
        .rd_data1_o (rf_rdata1),
        .rd_data2_o (rf_rdata2),
        .wr_en_i    (state_q == REG_WRITE && rf_we),
        .wr_addr_i  (rd),
        .wr_data_i  (rd_wdata)
    );

    assign imm_i = {{(`RV_XLEN-12){ir_q[31]}}, ir_q[31:20]};
    assign imm_u = {ir_q[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){ir_q[31]}}, ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OP:      begin op_a = rs1_q; op_b = rs2_q; end
            OP_IMM:  begin op_a = rs1_q; op_b = imm_i; end
            LUI:     begin op_a = '0;    op_b = imm_u; end
            AUIPC:   begin op_a = pc_q;  op_b = imm_u; end
            JAL:     begin op_a = pc_q;  op_b = imm_j; end
            JALR:    begin op_a = rs1_q; op_b = imm_i; end
            default: begin op_a = rs1_q; op_b = rs2_q; end
        endcase
    end

    rv_alu u_alu (
        .opcode_i    (opcode),
        .funct3_i    (alu_fn_e'(ir_q[14:12])),
        .funct7_b5_i (ir_q[30]),
        .op_a_i      (op_a),
        .op_b_i      (op_b),
        .result_o    (alu_res)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= RESET;
        end else begin
            case (state_q)
                RESET: state_q <= FETCH;
                FETCH: begin
                    if (wb_rsp_i.err || wb_rsp_i.rty) begin
                        state_q <= HALT;    // retry counts as an error.
                    end else if (wb_rsp_i.ack) begin
                        state_q <= REG_READ;
                    end
                end
                REG_READ:  state_q <= EXECUTE;
                EXECUTE:   state_q <= MEMORY;
                MEMORY:    state_q <= REG_WRITE;    // empty slot for now.
                REG_WRITE: state_q <= FETCH;
                HALT:      state_q <= HALT;
                default:   state_q <= RESET;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (state_q == REG_WRITE) begin
            pc_q <= next_pc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FETCH && wb_rsp_i.ack) begin
            ir_q <= wb_rsp_i.dat;
        end
        if (state_q == REG_READ) begin
            rs1_q <= rf_rdata1;
            rs2_q <= rf_rdata2;
        end
        if (state_q == EXECUTE) begin
            alu_res_q <= alu_res;
        end
    end

    assign writes_rd = opcode inside {OP_IMM, LUI, AUIPC, OP, JAL, JALR};
    assign rf_we     = writes_rd && (rd != 5'd0);
    assign pc_plus4  = pc_q + `RV_XLEN'd4;

    always_comb begin
        case (opcode)
            JAL: begin
                rd_wdata = pc_plus4;
                next_pc  = alu_res_q;
            end
            JALR: begin
                rd_wdata = pc_plus4;
                next_pc  = {alu_res_q[`RV_XLEN-1:1], 1'b0};
            end
            default: begin
                rd_wdata = alu_res_q;
                next_pc  = pc_plus4;
            end
        endcase
    end

    always_comb begin
        wb_req_o.adr = pc_q;
        wb_req_o.dat = '0;
        wb_req_o.sel = 4'hf;
        wb_req_o.we  = 1'b0;    // fetch only.
        wb_req_o.stb = (state_q == FETCH);
        wb_req_o.cyc = (state_q == FETCH);
    end

    always_comb begin
        retire_o.valid = (state_q == REG_WRITE);
        retire_o.pc    = pc_q;
        retire_o.rd    = rd;
        retire_o.wdata = rd_wdata;
        retire_o.we    = rf_we;
    end

    assign halt_o = (state_q == HALT);

endmodule

// File: hdl/rv_alu.sv
`include "rv_macros.svh"

module rv_alu
    import rv_isa_pkg::*;
(
    input  opcode_e             opcode_i,
    input  alu_fn_e             funct3_i,
    input  logic                funct7_b5_i,
    input  logic [`RV_XLEN-1:0] op_a_i,
    input  logic [`RV_XLEN-1:0] op_b_i,
    output logic [`RV_XLEN-1:0] result_o
);

    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] diff;
    logic                lt_s;
    logic                lt_u;
    logic                is_alu_op;

    assign shamt     = op_b_i[4:0];
    assign sum       = op_a_i + op_b_i;
    assign diff      = op_a_i - op_b_i;
    assign lt_s      = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u      = op_a_i < op_b_i;
    assign is_alu_op = (opcode_i == OP) || (opcode_i == OP_IMM);

    always_comb begin
        if (is_alu_op) begin
            case (funct3_i)
                ADD_SUB: begin
                    // immediates have no subtract form.
                    if (opcode_i == OP && funct7_b5_i) begin
                        result_o = diff;
                    end else begin
                        result_o = sum;
                    end
                end
                SLL:  result_o = op_a_i << shamt;
                SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
                SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
                XOR:  result_o = op_a_i ^ op_b_i;
                SRL_SRA: begin
                    if (funct7_b5_i) begin
                        result_o = $signed(op_a_i) >>> shamt;
                    end else begin
                        result_o = op_a_i >> shamt;
                    end
                end
                OR:      result_o = op_a_i | op_b_i;
                AND:     result_o = op_a_i & op_b_i;
                default: result_o = sum;
            endcase
        end else begin
            result_o = sum;    // lui, auipc and jump targets.
        end
    end

endmodule

// File: hdl/rv_regfile.sv
`include "rv_macros.svh"

module rv_regfile (
    input  logic                clk_i,
    input  logic [4:0]          rd_addr1_i,
    input  logic [4:0]          rd_addr2_i,
    output logic [`RV_XLEN-1:0] rd_data1_o,
    output logic [`RV_XLEN-1:0] rd_data2_o,
    input  logic                wr_en_i,
    input  logic [4:0]          wr_addr_i,
    input  logic [`RV_XLEN-1:0] wr_data_i
);

    logic [`RV_XLEN-1:0] regs [1:31];   // x0 has no storage.

    always_ff @(posedge clk_i) begin
        if (wr_en_i && wr_addr_i != 5'd0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        if (rd_addr1_i == 5'd0) begin
            rd_data1_o = '0;
        end else begin
            rd_data1_o = regs[rd_addr1_i];
        end
        if (rd_addr2_i == 5'd0) begin
            rd_data2_o = '0;
        end else begin
            rd_data2_o = regs[rd_addr2_i];
        end
    end

endmodule

// File: hdl/wb_pkg.sv
package wb_pkg;

    // master to slave.
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    // slave to master.
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
        logic        rty;
    } wb_rsp_t;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes the core executes.
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        OP     = 7'b0110011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // funct3 field of OP and OP_IMM.
    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } alu_fn_e;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        REG_READ  = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        REG_WRITE = 3'd4,
        HALT      = 3'd6,
        RESET     = 3'd7
    } cpu_state_e;

    // one record per retired instruction.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        we;    // low when nothing is written.
    } retire_t;

endpackage

// File: hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// integer register and data path width.
`define RV_XLEN 32

// depth of the on-chip word RAM.
`define RV_MEM_WORDS 256

// byte address of the first fetch after reset.
`define RV_RESET_PC 32'h0000_0000

`endif
